//--- hw/pdp8_word_pkg.sv
// word, field and character types plus the instruction word union, imported by all IOT RTL
package pdp8_word_pkg;

    // bit 0 is the msb, as on the real machine
    typedef logic [0:11] word_t;
    typedef logic [0:2]  field_t;
    typedef logic [0:7]  char_t;

    localparam logic [0:2] OP_IOT = 3'o6;

    // generic IOT layout, 6DDP
    typedef struct packed
    {
        logic [0:2] opcode;
        logic [0:5] device;
        logic [0:2] pulse;
    } iot_view_t;

    // memory extension layout, 62FP
    typedef struct packed
    {
        logic [0:2] opcode;
        logic [0:2] group;   // 2 for memory extension
        field_t     field;
        logic [0:2] pulse;
    } mex_view_t;

    // same instruction word, two decodes
    typedef union packed
    {
        iot_view_t iot;
        mex_view_t mex;
    } iot_word_u;

endpackage

//--- hw/pdp8_iot_pkg.sv
// IOT device codes, function codes and pulse bit positions for the device decoders
package pdp8_iot_pkg;

    // device codes, octal as in the handbook
    localparam logic [0:5] DEV_INT = 6'o00;
    localparam logic [0:5] DEV_KBD = 6'o03;
    localparam logic [0:5] DEV_TP  = 6'o04;

    // memory extension occupies devices 20 through 27
    localparam logic [0:2] MEX_GROUP = 3'o2;

    // 62x4 read group, selected by the field bits
    localparam logic [0:2] MEX_RDF = 3'o1;
    localparam logic [0:2] MEX_RIF = 3'o2;
    localparam logic [0:2] MEX_RIB = 3'o3;
    localparam logic [0:2] MEX_RMF = 3'o4;

    // device 00 is decoded on the whole pulse field
    localparam logic [0:2] INT_SKON = 3'o0;
    localparam logic [0:2] INT_ION  = 3'o1;
    localparam logic [0:2] INT_IOF  = 3'o2;
    localparam logic [0:2] INT_RTF  = 3'o5;

    // positions inside the pulse field, msb first
    localparam int PULSE_4 = 0;
    localparam int PULSE_2 = 1;
    localparam int PULSE_1 = 2;

endpackage

//--- hw/console_iot.sv
// console IOT decoder for keyboard (03) and teleprinter (04), parallel character transfer
module console_iot (
    input  logic                     clk,
    input  logic                     rst,
    input  pdp8_word_pkg::iot_word_u instruction,
    input  pdp8_word_pkg::word_t     ac,
    input  logic                     iot_strobe,
    input  logic                     kbd_strobe,
    input  pdp8_word_pkg::char_t     kbd_data,
    input  logic                     tp_done,
    output pdp8_word_pkg::word_t     kbd_bus,
    output logic                     kbd_skip,
    output logic                     kbd_ac_clear,
    output logic                     kbd_flag,
    output logic                     tp_flag,
    output logic                     tp_strobe,
    output pdp8_word_pkg::char_t     tp_data
);
    import pdp8_word_pkg::*;
    import pdp8_iot_pkg::*;

    char_t      kbd_buf;
    logic       is_iot;
    logic       kbd_sel;
    logic       tp_sel;
    logic [0:2] pulse;
    logic       kbd_clear;
    logic       tp_clear;
    logic       tp_load;

    assign is_iot  = (instruction.iot.opcode == OP_IOT);
    assign kbd_sel = is_iot && (instruction.iot.device == DEV_KBD);
    assign tp_sel  = is_iot && (instruction.iot.device == DEV_TP);
    assign pulse   = instruction.iot.pulse;

    // register effects only on the execute cycle
    assign kbd_clear = iot_strobe && kbd_sel && pulse[PULSE_2];  // KCC, KRB
    assign tp_clear  = iot_strobe && tp_sel && pulse[PULSE_2];   // TCF, TLS
    assign tp_load   = iot_strobe && tp_sel && pulse[PULSE_4];   // TPC, TLS

    // one skip line serves both console devices
    assign kbd_skip = (kbd_sel && pulse[PULSE_1] && kbd_flag)
                    || (tp_sel && pulse[PULSE_1] && tp_flag);

    assign kbd_ac_clear = kbd_sel && pulse[PULSE_2];

    // KRS, KRB put the character in bits 4-11
    assign kbd_bus = (kbd_sel && pulse[PULSE_4]) ? {4'b0000, kbd_buf} : '0;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            kbd_flag  <= 1'b0;
            tp_flag   <= 1'b0;
            tp_strobe <= 1'b0;
        end
        else
        begin
            // a new character beats a clear in the same cycle
            if (kbd_strobe)
            begin
                kbd_flag <= 1'b1;
            end
            else if (kbd_clear)
            begin
                kbd_flag <= 1'b0;
            end

            // same rule on the printer side
            if (tp_done)
            begin
                tp_flag <= 1'b1;
            end
            else if (tp_clear)
            begin
                tp_flag <= 1'b0;
            end

            tp_strobe <= tp_load;  // one cycle after TPC or TLS
        end
    end

    always_ff @(posedge clk)
    begin
        if (kbd_strobe)
        begin
            kbd_buf <= kbd_data;
        end
        if (tp_load)
        begin
            tp_data <= ac[4:11];  // low byte of ac
        end
    end

endmodule

//--- hw/ext_mem_iot.sv
// memory extension (62) and interrupt control (00) IOT decoder, holds fields and enable state
module ext_mem_iot (
    input  logic                     clk,
    input  logic                     rst,
    input  pdp8_word_pkg::iot_word_u instruction,
    input  pdp8_word_pkg::word_t     ac,
    input  logic                     iot_strobe,
    input  logic                     branch,
    input  logic                     int_taken,
    output pdp8_word_pkg::word_t     mex_bus,
    output logic                     mex_skip,
    output logic                     int_ena,
    output logic                     int_inh,
    output pdp8_word_pkg::field_t    if_field,
    output pdp8_word_pkg::field_t    df_field
);
    import pdp8_word_pkg::*;
    import pdp8_iot_pkg::*;

    field_t     ib_field;
    logic [0:5] save_field;  // if and df at interrupt time
    logic       is_iot;
    logic       int_sel;
    logic       mex_sel;
    logic [0:2] pulse;
    logic       rd_grp;
    logic       cdf;
    logic       cif;
    logic       rmf;
    logic       skon;
    logic       ion;
    logic       iof;
    logic       rtf;

    assign is_iot  = (instruction.iot.opcode == OP_IOT);
    assign int_sel = is_iot && (instruction.iot.device == DEV_INT);
    assign mex_sel = is_iot && (instruction.mex.group == MEX_GROUP);
    assign pulse   = instruction.iot.pulse;

    // 62x4 only, pulses 1 and 2 belong to CDF and CIF
    assign rd_grp = mex_sel && (pulse == 3'b100);

    assign cdf  = mex_sel && pulse[PULSE_1];
    assign cif  = mex_sel && pulse[PULSE_2];
    assign rmf  = rd_grp && (instruction.mex.field == MEX_RMF);
    assign skon = int_sel && (pulse == INT_SKON);
    assign ion  = int_sel && (pulse == INT_ION);
    assign iof  = int_sel && (pulse == INT_IOF);
    assign rtf  = int_sel && (pulse == INT_RTF);

    assign mex_skip = skon && int_ena;

    always_comb
    begin
        mex_bus = '0;
        if (rd_grp)
        begin
            case (instruction.mex.field)
                MEX_RDF: mex_bus[6:8]  = df_field;
                MEX_RIF: mex_bus[6:8]  = if_field;
                MEX_RIB: mex_bus[6:11] = save_field;
                default: mex_bus       = '0;  // RMF reads nothing
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            if_field   <= '0;
            df_field   <= '0;
            ib_field   <= '0;
            save_field <= '0;
            int_ena    <= 1'b0;
            int_inh    <= 1'b0;
        end
        else
        begin
            // JMP or JMS completes a pending CIF
            if (branch)
            begin
                if_field <= ib_field;
                int_inh  <= 1'b0;
            end

            if (iot_strobe)
            begin
                if (cdf)
                begin
                    df_field <= instruction.mex.field;
                end
                if (cif)
                begin
                    ib_field <= instruction.mex.field;
                    int_inh  <= 1'b1;
                end
                if (rmf)
                begin
                    ib_field <= save_field[0:2];
                    df_field <= save_field[3:5];
                    int_inh  <= 1'b1;
                end
                if (ion)
                begin
                    int_ena <= 1'b1;
                end
                if (iof || skon)
                begin
                    int_ena <= 1'b0;
                end
                // RTF reloads buffer and data field from ac 6-11, then enables
                if (rtf)
                begin
                    ib_field <= ac[6:8];
                    df_field <= ac[9:11];
                    int_ena  <= 1'b1;
                    int_inh  <= 1'b1;
                end
            end

            // interrupt forces field 0
            if (int_taken)
            begin
                save_field <= {if_field, df_field};
                if_field   <= '0;
                df_field   <= '0;
                ib_field   <= '0;
                int_ena    <= 1'b0;
            end
        end
    end

endmodule

//--- hw/iot_mux.sv
// merges device answers into the registered IOT reply and forms the interrupt request
module iot_mux (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 iot_strobe,
    input  pdp8_word_pkg::word_t kbd_bus,
    input  pdp8_word_pkg::word_t mex_bus,
    input  logic                 kbd_skip,
    input  logic                 mex_skip,
    input  logic                 kbd_ac_clear,
    input  logic                 kbd_flag,
    input  logic                 tp_flag,
    input  logic                 int_ena,
    input  logic                 int_inh,
    output pdp8_word_pkg::word_t in_bus,
    output logic                 skip,
    output logic                 ac_clear,
    output logic                 iot_ack,
    output logic                 int_req
);
    import pdp8_word_pkg::*;

    word_t merged_bus;
    logic  merged_skip;

    // devices drive zero when not addressed
    assign merged_bus  = kbd_bus | mex_bus;
    assign merged_skip = kbd_skip | mex_skip;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            iot_ack  <= 1'b0;
            in_bus   <= '0;
            skip     <= 1'b0;
            ac_clear <= 1'b0;
        end
        else
        begin
            iot_ack  <= iot_strobe;
            in_bus   <= iot_strobe ? merged_bus : '0;  // zero outside the ack cycle
            skip     <= iot_strobe && merged_skip;
            ac_clear <= iot_strobe && kbd_ac_clear;
        end
    end

    assign int_req = int_ena && !int_inh && (kbd_flag || tp_flag);

endmodule

//--- hw/iot_unit.sv
// IOT subsystem top level, console and memory extension decoders behind the reply mux
module iot_unit (
    input  logic                     clk,
    input  logic                     rst,
    input  pdp8_word_pkg::iot_word_u instruction,
    input  pdp8_word_pkg::word_t     ac,
    input  logic                     iot_strobe,
    input  logic                     branch,
    input  logic                     int_taken,
    input  logic                     kbd_strobe,
    input  pdp8_word_pkg::char_t     kbd_data,
    input  logic                     tp_done,
    output pdp8_word_pkg::word_t     in_bus,
    output logic                     skip,
    output logic                     ac_clear,
    output logic                     iot_ack,
    output logic                     int_req,
    output logic                     tp_strobe,
    output pdp8_word_pkg::char_t     tp_data,
    output pdp8_word_pkg::field_t    if_field,
    output pdp8_word_pkg::field_t    df_field
);
    import pdp8_word_pkg::*;

    word_t kbd_bus;
    word_t mex_bus;
    logic  kbd_skip;
    logic  mex_skip;
    logic  kbd_ac_clear;
    logic  kbd_flag;
    logic  tp_flag;
    logic  int_ena;
    logic  int_inh;

    console_iot u_console (
        .clk          (clk),
        .rst          (rst),
        .instruction  (instruction),
        .ac           (ac),
        .iot_strobe   (iot_strobe),
        .kbd_strobe   (kbd_strobe),
        .kbd_data     (kbd_data),
        .tp_done      (tp_done),
        .kbd_bus      (kbd_bus),
        .kbd_skip     (kbd_skip),
        .kbd_ac_clear (kbd_ac_clear),
        .kbd_flag     (kbd_flag),
        .tp_flag      (tp_flag),
        .tp_strobe    (tp_strobe),
        .tp_data      (tp_data)
    );

    ext_mem_iot u_ext_mem (
        .clk         (clk),
        .rst         (rst),
        .instruction (instruction),
        .ac          (ac),
        .iot_strobe  (iot_strobe),
        .branch      (branch),
        .int_taken   (int_taken),
        .mex_bus     (mex_bus),
        .mex_skip    (mex_skip),
        .int_ena     (int_ena),
        .int_inh     (int_inh),
        .if_field    (if_field),
        .df_field    (df_field)
    );

    iot_mux u_mux (
        .clk          (clk),
        .rst          (rst),
        .iot_strobe   (iot_strobe),
        .kbd_bus      (kbd_bus),
        .mex_bus      (mex_bus),
        .kbd_skip     (kbd_skip),
        .mex_skip     (mex_skip),
        .kbd_ac_clear (kbd_ac_clear),
        .kbd_flag     (kbd_flag),
        .tp_flag      (tp_flag),
        .int_ena      (int_ena),
        .int_inh      (int_inh),
        .in_bus       (in_bus),
        .skip         (skip),
        .ac_clear     (ac_clear),
        .iot_ack      (iot_ack),
        .int_req      (int_req)
    );

endmodule

//--- bench/iot_unit_asserts.sv
// concurrent checks on the iot_unit reply timing and interrupt gating, attached by bind
module iot_unit_asserts (
    input logic                     clk,
    input logic                     rst,
    input pdp8_word_pkg::iot_word_u instruction,
    input logic                     iot_strobe,
    input logic                     iot_ack,
    input pdp8_word_pkg::word_t     in_bus,
    input logic                     skip,
    input logic                     ac_clear,
    input logic                     tp_strobe,
    input logic                     int_req,
    input logic                     int_inh
);
    import pdp8_word_pkg::*;
    import pdp8_iot_pkg::*;

    logic sets_inh;

    // CIF (62x2, 62x3) and RMF raise the inhibit
    assign sets_inh = (instruction.mex.opcode == OP_IOT)
                    && (instruction.mex.group == MEX_GROUP)
                    && (instruction.mex.pulse[PULSE_2]
                        || (instruction.mex.pulse == 3'o4
                            && instruction.mex.field == MEX_RMF));

    ack_follows_strobe: assert property (@(posedge clk) disable iff (rst)
        iot_strobe |=> iot_ack)
        else $error("iot_ack missing after iot_strobe");

    no_ack_without_strobe: assert property (@(posedge clk) disable iff (rst)
        !iot_strobe |=> !iot_ack)
        else $error("iot_ack without iot_strobe");

    quiet_without_ack: assert property (@(posedge clk) disable iff (rst)
        !iot_ack |-> (in_bus == '0) && !skip && !ac_clear)
        else $error("reply lines active without iot_ack");

    // a second strobe cycle only comes from a back-to-back TLS
    tp_strobe_single: assert property (@(posedge clk) disable iff (rst)
        tp_strobe |=> !tp_strobe || $past(iot_strobe))
        else $error("tp_strobe longer than one cycle");

    // inhibit holds the request off right after the field change
    no_req_when_inhibited: assert property (@(posedge clk) disable iff (rst)
        iot_strobe && sets_inh |=> int_inh && !int_req)
        else $error("int_req not held off after CIF or RMF");

endmodule

bind iot_unit iot_unit_asserts u_asserts (
    .clk         (clk),
    .rst         (rst),
    .instruction (instruction),
    .iot_strobe  (iot_strobe),
    .iot_ack     (iot_ack),
    .in_bus      (in_bus),
    .skip        (skip),
    .ac_clear    (ac_clear),
    .tp_strobe   (tp_strobe),
    .int_req     (int_req),
    .int_inh     (int_inh)
);

//--- bench/iot_unit_tb.sv
// random IOT testbench for iot_unit, checks every cycle against a reference model
module iot_unit_tb;
    import pdp8_word_pkg::*;

    localparam int RANDOM_CYCLES = 4000;
    localparam int WAIT_LIMIT    = 50;

    logic      clk = 1'b0;
    logic      rst;
    iot_word_u instruction;
    word_t     ac;
    logic      iot_strobe, branch, int_taken, kbd_strobe, tp_done;
    char_t     kbd_data;
    word_t     in_bus;
    logic      skip, ac_clear, iot_ack, int_req, tp_strobe;
    char_t     tp_data;
    field_t    if_field, df_field;

    // inputs as the DUT sees them in the current cycle
    word_t  cur_ins, cur_ac;
    logic   cur_strobe, cur_branch, cur_taken, cur_kstb, cur_tdone;
    char_t  cur_kdata;

    // model state
    logic       m_kflag, m_tflag, m_tstb, m_tvalid, m_ena, m_inh, m_ack, m_skip, m_clr;
    char_t      m_kbuf, m_tdata;
    field_t     m_if, m_df, m_ib;
    logic [0:5] m_sv;
    word_t      m_bus;
    logic [31:0] seed = 32'h5c11;

    iot_unit dut (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [14:0] draw();
        seed = lcg_next(seed);
        return seed[30:16];
    endfunction

    task automatic fail_value(input string name, input logic [11:0] got, input logic [11:0] exp);
        $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            fail_value(name, got, exp);
    endtask

    task automatic check_field(input string name, input field_t got, input field_t exp);
        if (got !== exp)
            fail_value(name, 12'(got), 12'(exp));
    endtask

    task automatic check_char(input string name, input char_t got, input char_t exp);
        if (got !== exp)
            fail_value(name, 12'(got), 12'(exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_value(name, 12'(got), 12'(exp));
    endtask

    // one clock edge of the model, using the inputs the DUT just sampled
    task automatic update_model();
        logic [0:2] op, p, fld, grp;
        logic [0:5] dev;
        logic       kbd, tp, intd, mex, rd, tload;
        word_t      bus;
        field_t     n_if, n_df, n_ib;
        logic       n_ena, n_inh;
        op   = cur_ins[0:2];
        dev  = cur_ins[3:8];
        grp  = cur_ins[3:5];
        fld  = cur_ins[6:8];
        p    = cur_ins[9:11];
        kbd  = (op == 3'o6) && (dev == 6'o03);
        tp   = (op == 3'o6) && (dev == 6'o04);
        intd = (op == 3'o6) && (dev == 6'o00);
        mex  = (op == 3'o6) && (grp == 3'o2);
        rd   = mex && (p == 3'o4);
        bus  = '0;
        if (kbd && p[0])
            bus[4:11] = m_kbuf;  // KRS, KRB
        if (rd && fld == 3'o1)
            bus[6:8] = m_df;
        if (rd && fld == 3'o2)
            bus[6:8] = m_if;
        if (rd && fld == 3'o3)
            bus[6:11] = m_sv;
        m_ack  = cur_strobe;
        m_bus  = cur_strobe ? bus : '0;
        m_skip = cur_strobe && ((kbd && p[2] && m_kflag) || (tp && p[2] && m_tflag)
                 || (intd && p == 3'o0 && m_ena));
        m_clr  = cur_strobe && kbd && p[1];
        tload  = cur_strobe && tp && p[0];
        m_tstb = tload;
        if (tload)
        begin
            m_tdata  = cur_ac[4:11];
            m_tvalid = 1'b1;
        end
        m_kflag = cur_kstb ? 1'b1 : ((cur_strobe && kbd && p[1]) ? 1'b0 : m_kflag);
        m_tflag = cur_tdone ? 1'b1 : ((cur_strobe && tp && p[1]) ? 1'b0 : m_tflag);
        if (cur_kstb)
            m_kbuf = cur_kdata;
        n_if  = cur_branch ? m_ib : m_if;
        n_inh = cur_branch ? 1'b0 : m_inh;
        n_df  = m_df;
        n_ib  = m_ib;
        n_ena = m_ena;
        if (cur_strobe)
        begin
            if (mex && p[2])
                n_df = fld;  // CDF
            if (mex && p[1])
            begin
                n_ib  = fld;  // CIF
                n_inh = 1'b1;
            end
            if (rd && fld == 3'o4)
            begin
                n_ib  = m_sv[0:2];  // RMF
                n_df  = m_sv[3:5];
                n_inh = 1'b1;
            end
            if (intd && p == 3'o1)
                n_ena = 1'b1;
            if (intd && (p == 3'o2 || p == 3'o0))
                n_ena = 1'b0;
            if (intd && p == 3'o5)
            begin
                n_ib  = cur_ac[6:8];  // RTF
                n_df  = cur_ac[9:11];
                n_ena = 1'b1;
                n_inh = 1'b1;
            end
        end
        if (cur_taken)
        begin
            m_sv  = {m_if, m_df};
            n_if  = '0;
            n_df  = '0;
            n_ib  = '0;
            n_ena = 1'b0;
        end
        {m_if, m_df, m_ib, m_ena, m_inh} = {n_if, n_df, n_ib, n_ena, n_inh};
    endtask

    task automatic step(input word_t w, input word_t a, input logic s, input logic ks,
                        input char_t kd, input logic td, input logic br, input logic it);
        logic req;
        @(posedge clk);
        update_model();
        req = m_ena && !m_inh && (m_kflag || m_tflag);
        instruction <= w;
        ac          <= a;
        iot_strobe  <= s;
        kbd_strobe  <= ks;
        kbd_data    <= kd;
        tp_done     <= td;
        branch      <= br;
        int_taken   <= it && req;  // only when an interrupt is pending
        {cur_ins, cur_ac, cur_strobe, cur_kstb, cur_kdata} = {w, a, s, ks, kd};
        {cur_tdone, cur_branch, cur_taken} = {td, br, it && req};
        @(negedge clk);
        check_bit("iot_ack", iot_ack, m_ack);
        check_word("in_bus", in_bus, m_bus);
        check_bit("skip", skip, m_skip);
        check_bit("ac_clear", ac_clear, m_clr);
        check_bit("int_req", int_req, req);
        check_bit("tp_strobe", tp_strobe, m_tstb);
        check_field("if_field", if_field, m_if);
        check_field("df_field", df_field, m_df);
        if (m_tvalid)
            check_char("tp_data", tp_data, m_tdata);
    endtask

    function automatic word_t pick_instruction();
        logic [14:0] r;
        field_t      f;
        r = draw();
        f = r[14:12];
        case (r[4:0] % 23)
            0: return 12'o6031;
            1: return 12'o6032;
            2: return 12'o6034;
            3: return 12'o6036;
            4: return 12'o6041;
            5: return 12'o6042;
            6: return 12'o6044;
            7: return 12'o6046;
            8: return 12'o6000;
            9: return 12'o6001;
            10: return 12'o6002;
            11: return 12'o6005;
            12: return {6'o62, f, 3'o1};
            13: return {6'o62, f, 3'o2};
            14: return {6'o62, f, 3'o3};
            15: return 12'o6214;
            16: return 12'o6224;
            17: return 12'o6234;
            18: return 12'o6244;
            19: return 12'o6101;
            20: return 12'o6551;
            21: return 12'o7000;
            default: return 12'o6001;  // ION again, keeps interrupts active
        endcase
    endfunction

    initial
    begin
        int          n;
        logic [14:0] r;
        rst         <= 1'b1;
        instruction <= '0;
        ac          <= '0;
        iot_strobe  <= 1'b0;
        branch      <= 1'b0;
        int_taken   <= 1'b0;
        kbd_strobe  <= 1'b1;  // preload the keyboard buffer with zero
        kbd_data    <= '0;
        tp_done     <= 1'b0;
        {cur_ins, cur_ac, cur_strobe, cur_kstb, cur_kdata} = '0;
        {cur_tdone, cur_branch, cur_taken} = '0;
        {m_kflag, m_tflag, m_tstb, m_tvalid, m_ena, m_inh, m_ack, m_skip, m_clr} = '0;
        {m_kbuf, m_tdata, m_if, m_df, m_ib, m_sv, m_bus} = '0;
        repeat (10) @(posedge clk);
        rst        <= 1'b0;
        kbd_strobe <= 1'b0;

        for (int i = 0; i < RANDOM_CYCLES; i++)
        begin
            r = draw();
            step(pick_instruction(), word_t'(draw()), r[0], r[3:1] == 0, char_t'(draw()),
                 r[6:4] == 0, r[9:7] == 0, r[12:10] == 0);
        end

        // idle cycle drains a printer strobe left by the random phase
        step(12'o7000, '0, 1'b0, 1'b0, '0, 1'b0, 1'b0, 1'b0);
        // directed TLS, then wait for the printer strobe
        step(12'o6046, 12'o5252, 1'b1, 1'b0, '0, 1'b0, 1'b0, 1'b0);
        n = 0;
        while (!tp_strobe)
        begin
            if (n == WAIT_LIMIT)
            begin
                $display("timeout: tp_strobe never followed TLS");
                $display("Test failures found");
                $fatal(1);
            end
            else
            begin
                step(12'o7000, '0, 1'b0, 1'b0, '0, 1'b0, 1'b0, 1'b0);
                n++;
            end
        end
        check_char("tp_data", tp_data, 8'o252);
        repeat (3) step(12'o7000, '0, 1'b0, 1'b0, '0, 1'b0, 1'b0, 1'b0);

        $display("All tests passed!");
        $finish;
    end

endmodule

//--- sources.f
hw/pdp8_word_pkg.sv
hw/pdp8_iot_pkg.sv
hw/console_iot.sv
hw/ext_mem_iot.sv
hw/iot_mux.sv
hw/iot_unit.sv
bench/iot_unit_asserts.sv
bench/iot_unit_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wall -Wno-fatal
TOP       ?= iot_unit_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Test failures found
PASS_MSG  := All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
